/* design/dump_defines.svh */
`ifndef DUMP_DEFINES_SVH
`define DUMP_DEFINES_SVH

// log2 of buffer words, also sets capture index width
`define DUMP_DEPTH_LOG2 5

// log2 of clocks between two captures
`define DUMP_PACE_LOG2 4

// clocks per uart bit
`define DUMP_CLKS_PER_BIT 8

`endif

/* design/dump_pkg.sv */
`include "dump_defines.svh"

package dump_pkg;

    typedef logic [7:0] sample_t;   // raw sample
    typedef logic [7:0] byte_t;     // uart byte
    typedef logic [15:0] word_t;    // {index, sample}

    // buffer address, top bit flags a full buffer
    typedef logic [`DUMP_DEPTH_LOG2:0] addr_t;

    typedef enum logic [2:0] {
        idle,
        capture,
        fetch,
        send_lo,
        send_hi,
        finish
    } dump_state_t;

endpackage

/* design/ram_port_if.sv */
`timescale 1ns/1ns

interface ram_port_if;

    logic we;
    dump_pkg::addr_t addr;
    dump_pkg::word_t wdata;
    dump_pkg::word_t rdata;   // word at last cycle's addr

    modport master (
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport memory (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* design/sample_pacer.sv */
`timescale 1ns/1ns
`include "dump_defines.svh"

module sample_pacer (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic pace
);

    logic [`DUMP_PACE_LOG2-1:0] cnt;

    // pace fires on the cycle after the counter wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            pace <= 1'b0;
        end else if (restart) begin
            cnt  <= '0;
            pace <= 1'b0;   // full interval before next strobe
        end else begin
            cnt  <= cnt + 1'b1;
            pace <= &cnt;
        end
    end

endmodule

/* design/capture_ram.sv */
`timescale 1ns/1ns
`include "dump_defines.svh"

module capture_ram (
    input logic clk,
    ram_port_if.memory mem
);

    dump_pkg::word_t store [2**`DUMP_DEPTH_LOG2];

    logic [`DUMP_DEPTH_LOG2-1:0] index;

    assign index = mem.addr[`DUMP_DEPTH_LOG2-1:0];   // wrap bit dropped

    always_ff @(posedge clk) begin
        if (mem.we) begin
            store[index] <= mem.wdata;
        end
        mem.rdata <= store[index];   // read before write
    end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ns
`include "dump_defines.svh"

module uart_tx (
    input  logic clk,
    input  logic rst,
    input  dump_pkg::byte_t tx_byte,
    input  logic tx_req,
    output logic tx_ack,
    output logic tx
);

    logic busy;
    logic [8:0] shifter;    // data bits, stop bit on top
    logic [3:0] bit_cnt;    // 0 start, 1..8 data, 9 stop
    logic [15:0] clk_cnt;
    logic bit_end;

    assign bit_end = (clk_cnt == 16'(`DUMP_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            tx_ack  <= 1'b0;
            tx      <= 1'b1;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end else if (!busy) begin
            tx <= 1'b1;
            if (tx_ack && !tx_req) begin
                tx_ack <= 1'b0;   // frame over and request withdrawn
            end else if (tx_req && !tx_ack) begin
                shifter <= {1'b1, tx_byte};
                busy    <= 1'b1;
                tx_ack  <= 1'b1;
                tx      <= 1'b0;   // start bit
                bit_cnt <= '0;
                clk_cnt <= '0;
            end
        end else begin
            if (bit_end) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    tx      <= shifter[0];
                    shifter <= {1'b1, shifter[8:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/dump_ctrl.sv */
`timescale 1ns/1ns
`include "dump_defines.svh"

module dump_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic arm,
    input  dump_pkg::sample_t sample,
    input  logic pace,
    output logic restart,
    ram_port_if.master ram,
    output dump_pkg::byte_t tx_byte,
    output logic tx_req,
    input  logic tx_ack,
    output logic sample_taken,
    output logic capturing,
    output logic done
);

    dump_pkg::dump_state_t state;
    dump_pkg::addr_t addr;
    logic full;
    logic write_en;
    logic link_free;

    assign full      = addr[`DUMP_DEPTH_LOG2];   // wrap bit
    assign link_free = !tx_req && !tx_ack;

    assign write_en = (state == dump_pkg::capture) && pace && !arm && !full;

    assign restart      = arm;
    assign sample_taken = write_en;
    assign capturing    = (state == dump_pkg::capture);
    assign done         = (state == dump_pkg::finish);

    assign ram.we    = write_en;
    assign ram.addr  = addr;
    assign ram.wdata = {dump_pkg::byte_t'(addr[`DUMP_DEPTH_LOG2-1:0]), sample};

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= dump_pkg::idle;
            addr   <= '0;
            tx_req <= 1'b0;
        end else if (arm) begin
            state  <= dump_pkg::capture;   // abandons any dump in flight
            addr   <= '0;
            tx_req <= 1'b0;
        end else begin
            case (state)
                dump_pkg::capture: begin
                    if (full) begin
                        state <= dump_pkg::fetch;
                        addr  <= '0;
                    end else if (write_en) begin
                        addr <= addr + 1'b1;
                    end
                end
                dump_pkg::fetch: begin
                    if (!full) begin
                        state <= dump_pkg::send_lo;   // rdata valid next cycle
                    end else if (!tx_ack) begin
                        state <= dump_pkg::finish;    // last frame has left the line
                    end
                end
                dump_pkg::send_lo: begin
                    if (link_free) begin
                        tx_byte <= ram.rdata[7:0];
                        tx_req  <= 1'b1;
                    end else if (tx_req && tx_ack) begin
                        tx_req <= 1'b0;
                        state  <= dump_pkg::send_hi;
                    end
                end
                dump_pkg::send_hi: begin
                    if (link_free) begin
                        tx_byte <= ram.rdata[15:8];
                        tx_req  <= 1'b1;
                    end else if (tx_req && tx_ack) begin
                        tx_req <= 1'b0;
                        addr   <= addr + 1'b1;
                        state  <= dump_pkg::fetch;
                    end
                end
                default: begin
                    // idle and finish wait for arm
                end
            endcase
        end
    end

endmodule

/* design/hex_dump_top.sv */
`timescale 1ns/1ns

module hex_dump_top (
    input  logic clk,
    input  logic rst,
    input  logic arm,
    input  logic [7:0] sample,
    output logic sample_taken,
    output logic tx,
    output logic capturing,
    output logic done
);

    logic pace;
    logic restart;
    dump_pkg::byte_t tx_byte;
    logic tx_req;
    logic tx_ack;

    ram_port_if ram_bus ();

    sample_pacer u_pacer (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .pace    (pace)
    );

    capture_ram u_ram (
        .clk (clk),
        .mem (ram_bus.memory)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .tx_byte (tx_byte),
        .tx_req  (tx_req),
        .tx_ack  (tx_ack),
        .tx      (tx)
    );

    dump_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .arm          (arm),
        .sample       (sample),
        .pace         (pace),
        .restart      (restart),
        .ram          (ram_bus.master),
        .tx_byte      (tx_byte),
        .tx_req       (tx_req),
        .tx_ack       (tx_ack),
        .sample_taken (sample_taken),
        .capturing    (capturing),
        .done         (done)
    );

endmodule

/* testbench/dump_checker.sv */
`timescale 1ns/1ns

module dump_checker (
    input logic clk,
    input logic rst,
    input dump_pkg::byte_t tx_byte,
    input logic tx_req,
    input logic tx_ack,
    input logic we,
    input dump_pkg::dump_state_t state,
    input logic done,
    input logic capturing
);

    int fault_cnt = 0;

    a_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_req) |-> !$past(tx_ack))   // ack seen at the rising edge
        else begin
            fault_cnt++;
            $error("tx_req rose while tx_ack was still high");
        end

    a_byte_hold: assert property (@(posedge clk) disable iff (rst)
        tx_req && $past(tx_req) |-> $stable(tx_byte))   // byte held for the whole request
        else begin
            fault_cnt++;
            $error("tx_byte changed while tx_req was high");
        end

    a_ack_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_ack) |-> !$past(tx_req))   // req seen at the falling edge
        else begin
            fault_cnt++;
            $error("tx_ack fell while tx_req was high");
        end

    a_we_state: assert property (@(posedge clk) disable iff (rst)
        we |-> state == dump_pkg::capture)
        else begin
            fault_cnt++;
            $error("buffer write outside the capture state");
        end

    a_done_excl: assert property (@(posedge clk) disable iff (rst)
        !(done && capturing))
        else begin
            fault_cnt++;
            $error("done and capturing were high together");
        end

endmodule

/* testbench/hex_dump_tb.sv */
`timescale 1ns/1ns
`include "dump_defines.svh"

module hex_dump_tb;

    localparam int DEPTH = 2**`DUMP_DEPTH_LOG2;
    localparam int PACE = 2**`DUMP_PACE_LOG2;
    localparam int CPB = `DUMP_CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 3 * (DEPTH * PACE + DEPTH * 20 * CPB);
    localparam logic [31:0] SEED = 32'h1033_509f;

    logic clk = 1'b0;
    logic rst;
    logic arm;
    dump_pkg::sample_t sample = SEED[7:0];
    logic sample_taken;
    logic tx;
    logic capturing;
    logic done;

    logic [31:0] rng = SEED;
    dump_pkg::sample_t samples [$];   // value present at each capture
    int taken_cnt = 0;
    int byte_cnt = 0;   // bytes decoded in the current run
    int cycle_cnt = 0;
    logic load_pending = 1'b0;
    logic was_capturing = 1'b0;
    logic exp_known = 1'b0;
    dump_pkg::byte_t exp_byte = '0;

    logic in_frame = 1'b0;
    logic frame_done = 1'b0;
    logic frame_stale = 1'b0;
    logic start_bit;
    logic stop_bit;
    dump_pkg::byte_t rx_byte;

    hex_dump_top UUT (
        .clk          (clk),
        .rst          (rst),
        .arm          (arm),
        .sample       (sample),
        .sample_taken (sample_taken),
        .tx           (tx),
        .capturing    (capturing),
        .done         (done)
    );

    bind hex_dump_top dump_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .tx_byte   (tx_byte),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .we        (ram_bus.we),
        .state     (u_ctrl.state),
        .done      (done),
        .capturing (capturing)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic pulse_arm();
        @(negedge clk);
        arm = 1'b1;
        @(negedge clk);
        arm = 1'b0;
    endtask

    // sample feed and expected byte for the next decoded frame
    always @(negedge clk) begin
        int pair_idx;
        if (load_pending) begin
            rng = next_random(rng);
            sample = rng[7:0];   // new value only after the write edge
            load_pending = 1'b0;
        end
        if (capturing && !was_capturing) begin
            samples.delete();
            taken_cnt = 0;
            byte_cnt = 0;
        end
        was_capturing = capturing;
        if (sample_taken) begin
            samples.push_back(sample);
            taken_cnt++;
            load_pending = 1'b1;
        end
        if (frame_done && !frame_stale) begin
            byte_cnt++;
        end
        pair_idx = byte_cnt / 2;
        exp_known = (pair_idx < samples.size());
        if (!exp_known) begin
            exp_byte = '0;
        end else if (byte_cnt % 2 == 0) begin
            exp_byte = samples[pair_idx];   // low byte is the sample
        end else begin
            exp_byte = dump_pkg::byte_t'(pair_idx);   // high byte is the index
        end
    end

    // uart decoder, samples near mid-bit
    initial begin
        forever begin
            @(negedge clk);
            frame_done <= 1'b0;
            if (!rst && tx === 1'b0) begin
                in_frame = 1'b1;
                repeat (CPB / 2 - 1) @(negedge clk);
                start_bit = tx;
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge clk);
                    rx_byte[i] = tx;
                end
                repeat (CPB) @(negedge clk);
                stop_bit = tx;
                frame_stale = capturing;   // tail of an abandoned dump
                frame_done <= 1'b1;
                in_frame = 1'b0;
            end
        end
    end

    a_byte_known: assert property (@(posedge clk) disable iff (rst)
        frame_done && !frame_stale |-> exp_known)
        else fail_run("a byte was decoded with no captured sample left to match it");

    a_byte_value: assert property (@(posedge clk) disable iff (rst)
        frame_done && !frame_stale |-> rx_byte == exp_byte)
        else fail_run($sformatf("ERR %0t rx_byte expected %02h actual %02h",
                                $time, exp_byte, rx_byte));

    a_start_bit: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> start_bit == 1'b0)
        else fail_run($sformatf("ERR %0t tx start bit expected 0 actual %b",
                                $time, start_bit));

    a_stop_bit: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> stop_bit == 1'b1)
        else fail_run($sformatf("ERR %0t tx stop bit expected 1 actual %b",
                                $time, stop_bit));

    a_idle_line: assert property (@(posedge clk) disable iff (rst)
        !in_frame || done |-> tx == 1'b1)
        else fail_run($sformatf("ERR %0t tx expected 1 actual %b", $time, tx));

    a_taken_cap: assert property (@(posedge clk) disable iff (rst)
        sample_taken |-> capturing)
        else fail_run("sample_taken pulsed outside capture");

    a_taken_count: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> taken_cnt == DEPTH)
        else fail_run($sformatf("ERR %0t sample_taken count expected %0d actual %0d",
                                $time, DEPTH, taken_cnt));

    a_byte_count: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> byte_cnt == 2 * DEPTH)
        else fail_run($sformatf("ERR %0t decoded byte count expected %0d actual %0d",
                                $time, 2 * DEPTH, byte_cnt));

    always @(negedge clk) begin
        if (UUT.u_checker.fault_cnt != 0) begin
            fail_run("the protocol checker flagged a violation");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the runs did not finish within the cycle limit");
        end
    end

    initial begin
        rst = 1'b1;
        arm = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        pulse_arm();
        wait (done);
        repeat (20) @(negedge clk);   // line idle while done
        pulse_arm();
        wait (byte_cnt == DEPTH);   // half the dump sent
        pulse_arm();
        wait (done);
        repeat (20) @(negedge clk);
        if (UUT.u_checker.fault_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("the protocol checker flagged a violation");
        end
    end

endmodule

/* src.f */
+incdir+design
design/dump_pkg.sv
design/ram_port_if.sv
design/sample_pacer.sv
design/capture_ram.sv
design/uart_tx.sv
design/dump_ctrl.sv
design/hex_dump_top.sv
testbench/dump_checker.sv
testbench/hex_dump_tb.sv

/* Bender.yml */
package:
  name: hex_dump

sources:
  - include_dirs:
      - design
    files:
      - design/dump_pkg.sv
      - design/ram_port_if.sv
      - design/sample_pacer.sv
      - design/capture_ram.sv
      - design/uart_tx.sv
      - design/dump_ctrl.sv
      - design/hex_dump_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/dump_checker.sv
      - testbench/hex_dump_tb.sv
